/* source/display_pkg.sv */
`default_nettype none

package display_pkg;

    localparam int unsigned DIGIT_W = 3;
    localparam int unsigned MATRIX_N = 8;

    localparam logic [DIGIT_W-1:0] DIGIT_MAX = 3'd5;
    localparam logic [DIGIT_W-1:0] DIGIT_BLANK = 3'd7; // empty frame

    typedef enum logic [1:0] {
        OFF    = 2'd0,
        RED    = 2'd1,
        YELLOW = 2'd2, // red and green leds together
        GREEN  = 2'd3
    } colour_t;

    // traffic order: high digits red, middle yellow, last two green
    function automatic colour_t colour_of(input logic [DIGIT_W-1:0] d);
        colour_t c;
        case (d)
            3'd5, 3'd4: c = RED;
            3'd3, 3'd2: c = YELLOW;
            3'd1, 3'd0: c = GREEN;
            default:    c = OFF;
        endcase
        return c;
    endfunction

endpackage

`default_nettype wire

/* source/apb_map_pkg.sv */
`default_nettype none

package apb_map_pkg;

    localparam int unsigned ADDR_W = 4;
    localparam int unsigned DATA_W = 32;

    localparam logic [ADDR_W-1:0] CTRL_OFS   = 4'h0;
    localparam logic [ADDR_W-1:0] LOAD_OFS   = 4'h4;
    localparam logic [ADDR_W-1:0] PERIOD_OFS = 4'h8;
    localparam logic [ADDR_W-1:0] STATUS_OFS = 4'hC;

    // CTRL
    localparam int unsigned CTRL_START_BIT = 0;

    // STATUS fields
    localparam int unsigned STATUS_DIGIT_LSB = 0;
    localparam int unsigned STATUS_RUN_BIT = 3;
    localparam int unsigned STATUS_DONE_BIT = 4;

endpackage

`default_nettype wire

/* source/countdown_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module countdown_regs
    import apb_map_pkg::*, display_pkg::*;
#(
    parameter int unsigned PERIOD_W = 16
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                psel,
    input  wire logic                penable,
    input  wire logic                pwrite,
    input  wire logic [ADDR_W-1:0]   paddr,
    input  wire logic [DATA_W-1:0]   pwdata,
    output logic      [DATA_W-1:0]   prdata,
    output logic                     pready,
    output logic                     pslverr,
    output logic      [DIGIT_W-1:0]  load_digit,
    output logic      [PERIOD_W-1:0] period,
    output logic                     start,
    input  wire logic [DIGIT_W-1:0]  digit,
    input  wire logic                running,
    input  wire logic                done
);

    logic                access;
    logic                hit_ctrl, hit_load, hit_period, hit_status;
    logic                mapped;
    logic                load_bad;
    logic                wr_ok;
    logic [DIGIT_W-1:0]  load_q;
    logic [PERIOD_W-1:0] period_q;

    assign access = psel && penable;

    assign hit_ctrl = (paddr == CTRL_OFS);
    assign hit_load = (paddr == LOAD_OFS);
    assign hit_period = (paddr == PERIOD_OFS);
    assign hit_status = (paddr == STATUS_OFS);
    assign mapped = hit_ctrl || hit_load || hit_period || hit_status;

    assign load_bad = pwrite && hit_load && (pwdata > DIGIT_MAX);
    assign pslverr = access && (!mapped || load_bad);
    assign pready = 1'b1; // no wait states

    assign wr_ok = access && pwrite && !pslverr;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            load_q <= '0;
            period_q <= '0;
        end
        else if (wr_ok)
        begin
            if (hit_load)
                load_q <= pwdata[DIGIT_W-1:0];
            if (hit_period)
                period_q <= pwdata[PERIOD_W-1:0];
        end
    end

    assign start = wr_ok && hit_ctrl && pwdata[CTRL_START_BIT];

    // read mux, only driven in the access cycle
    always_comb
    begin
        prdata = '0;
        if (access && !pwrite)
        begin
            if (hit_load)
                prdata[DIGIT_W-1:0] = load_q;
            if (hit_period)
                prdata[PERIOD_W-1:0] = period_q;
            if (hit_status)
            begin
                prdata[STATUS_DIGIT_LSB +: DIGIT_W] = digit;
                prdata[STATUS_RUN_BIT] = running;
                prdata[STATUS_DONE_BIT] = done;
            end
        end
    end

    assign load_digit = load_q;
    assign period = period_q;

endmodule

`default_nettype wire

/* source/countdown_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module countdown_unit
    import display_pkg::*;
#(
    parameter int unsigned PERIOD_W = 16
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic [DIGIT_W-1:0]  load_digit,
    input  wire logic [PERIOD_W-1:0] period,
    input  wire logic                start,
    output logic      [DIGIT_W-1:0]  digit,
    output logic                     running,
    output logic                     done,
    output logic      [DIGIT_W-1:0]  show_digit
);

    logic [PERIOD_W-1:0] pre_cnt;
    logic [PERIOD_W-1:0] last_cnt;
    logic                tick;

    // period of 0 behaves like 1
    assign last_cnt = (period == '0) ? '0 : period - 1'b1;
    assign tick = running && (pre_cnt == last_cnt);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            pre_cnt <= '0;
            digit <= DIGIT_BLANK;
            running <= 1'b0;
            done <= 1'b0;
        end
        else if (start)
        begin
            pre_cnt <= '0;
            digit <= load_digit;
            running <= (load_digit != '0);
            done <= (load_digit == '0); // zero load finishes at once
        end
        else if (tick)
        begin
            pre_cnt <= '0;
            digit <= digit - 1'b1;
            if (digit == 3'd1)
            begin
                running <= 1'b0;
                done <= 1'b1;
            end
        end
        else if (running)
            pre_cnt <= pre_cnt + 1'b1;
    end

    assign show_digit = digit; // blank until the first start

endmodule

`default_nettype wire

/* source/dot_matrix_scan.sv */
`timescale 1ns/1ps
`default_nettype none

module dot_matrix_scan
    import display_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic [DIGIT_W-1:0]  show_digit,
    output logic      [MATRIX_N-1:0] row,
    output logic      [MATRIX_N-1:0] colr,
    output logic      [MATRIX_N-1:0] colg
);

    localparam int unsigned ROW_W = $clog2(MATRIX_N);

    // one glyph per digit, row 0 on top
    localparam logic [MATRIX_N-1:0] GLYPH [0:DIGIT_MAX][0:MATRIX_N-1] = '{
        '{8'b0000_0000, 8'b0011_1100, 8'b0100_0010, 8'b0100_0010,
          8'b0100_0010, 8'b0100_0010, 8'b0100_0010, 8'b0011_1100},
        '{8'b0001_1000, 8'b0011_1000, 8'b0001_1000, 8'b0001_1000,
          8'b0001_1000, 8'b0001_1000, 8'b0001_1000, 8'b0111_1110},
        '{8'b0000_0000, 8'b0011_1100, 8'b0110_0110, 8'b0000_0110,
          8'b0000_1100, 8'b0011_0000, 8'b0110_0000, 8'b0111_1110},
        '{8'b0011_1100, 8'b0110_0110, 8'b0000_0110, 8'b0001_1100,
          8'b0000_0110, 8'b0110_0110, 8'b0011_1100, 8'b0000_0000},
        '{8'b0000_1100, 8'b0001_1100, 8'b0010_1100, 8'b0100_1100,
          8'b0111_1110, 8'b0000_1100, 8'b0000_1100, 8'b0000_0000},
        '{8'b0111_1110, 8'b0110_0000, 8'b0111_1100, 8'b0000_0110,
          8'b0000_0110, 8'b0110_0110, 8'b0011_1100, 8'b0000_0000}
    };

    logic [DIGIT_W-1:0]  digit_q;
    logic [ROW_W-1:0]    row_idx;
    logic [MATRIX_N-1:0] glyph_row;
    colour_t             colour;
    logic                red_on;
    logic                green_on;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            digit_q <= DIGIT_BLANK;
        else
            digit_q <= show_digit;
    end

    // no divider, next row every clk
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            row_idx <= '0;
        else if (row_idx == ROW_W'(MATRIX_N - 1))
            row_idx <= '0;
        else
            row_idx <= row_idx + 1'b1;
    end

    always_comb
    begin
        if (digit_q <= DIGIT_MAX)
            glyph_row = GLYPH[digit_q][row_idx];
        else
            glyph_row = '0; // blank code and unused codes
    end

    assign colour = colour_of(digit_q);
    assign red_on = (colour == RED) || (colour == YELLOW);
    assign green_on = (colour == GREEN) || (colour == YELLOW);

    // row select and columns leave together
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row <= '1;
            colr <= '0;
            colg <= '0;
        end
        else
        begin
            row <= ~(MATRIX_N'(1) << row_idx); // active low
            colr <= red_on ? glyph_row : '0;
            colg <= green_on ? glyph_row : '0;
        end
    end

endmodule

`default_nettype wire

/* source/countdown_display_top.sv */
`timescale 1ns/1ps
`default_nettype none

module countdown_display_top
    import apb_map_pkg::*, display_pkg::*;
#(
    parameter int unsigned PERIOD_W = 16
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                psel,
    input  wire logic                penable,
    input  wire logic                pwrite,
    input  wire logic [ADDR_W-1:0]   paddr,
    input  wire logic [DATA_W-1:0]   pwdata,
    output logic      [DATA_W-1:0]   prdata,
    output logic                     pready,
    output logic                     pslverr,
    output logic      [MATRIX_N-1:0] row,
    output logic      [MATRIX_N-1:0] colr,
    output logic      [MATRIX_N-1:0] colg,
    output logic                     expired
);

    logic [DIGIT_W-1:0]  load_digit;
    logic [PERIOD_W-1:0] period;
    logic                start;
    logic [DIGIT_W-1:0]  digit;
    logic                running;
    logic [DIGIT_W-1:0]  show_digit;

    countdown_regs #(
        .PERIOD_W   (PERIOD_W)
    ) u_regs (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .load_digit (load_digit),
        .period     (period),
        .start      (start),
        .digit      (digit),
        .running    (running),
        .done       (expired)
    );

    countdown_unit #(
        .PERIOD_W   (PERIOD_W)
    ) u_unit (
        .clk        (clk),
        .rst        (rst),
        .load_digit (load_digit),
        .period     (period),
        .start      (start),
        .digit      (digit),
        .running    (running),
        .done       (expired), // done doubles as the expiry level
        .show_digit (show_digit)
    );

    dot_matrix_scan u_scan (
        .clk        (clk),
        .rst        (rst),
        .show_digit (show_digit),
        .row        (row),
        .colr       (colr),
        .colg       (colg)
    );

endmodule

`default_nettype wire

/* verification/countdown_display_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module countdown_display_properties
    import display_pkg::*;
#(
    parameter bit SCAN_CHECKS = 1'b1 // scan side, else bus side
) (
    input wire logic                clk,
    input wire logic                rst,
    input wire logic [MATRIX_N-1:0] row,
    input wire logic [MATRIX_N-1:0] colr,
    input wire logic [MATRIX_N-1:0] colg,
    input wire logic                pready
);

    generate
        if (SCAN_CHECKS)
        begin : g_scan
            row_one_cold: assert property (@(posedge clk) disable iff (rst)
                !$past(rst) |-> $onehot(~row))
                else $error("row select does not have exactly one active bit");

            // zero bit moves one row down per cycle
            row_walk: assert property (@(posedge clk) disable iff (rst)
                (!$past(rst) && !$past(rst, 2)) |->
                row == {$past(row[MATRIX_N-2:0]), $past(row[MATRIX_N-1])})
                else $error("row select did not advance by one row");

            yellow_match: assert property (@(posedge clk) disable iff (rst)
                (colr != '0 && colg != '0) |-> colr == colg)
                else $error("red and green columns differ while both are lit");
        end
        else
        begin : g_apb
            pready_high: assert property (@(posedge clk) disable iff (rst) pready)
                else $error("pready went low");
        end
    endgenerate

endmodule

bind dot_matrix_scan countdown_display_properties #(.SCAN_CHECKS(1'b1)) u_scan_props (
    .clk    (clk),
    .rst    (rst),
    .row    (row),
    .colr   (colr),
    .colg   (colg),
    .pready (1'b1)
);

bind countdown_regs countdown_display_properties #(.SCAN_CHECKS(1'b0)) u_apb_props (
    .clk    (clk),
    .rst    (rst),
    .row    ('1),
    .colr   ('0),
    .colg   ('0),
    .pready (pready)
);

`default_nettype wire

/* verification/tb_countdown_display.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_countdown_display
    import apb_map_pkg::*, display_pkg::*;
();

    localparam int NRUNS = 6;
    localparam int HOLD = 16'hFFFF; // no tick while a frame is captured

    logic                clk;
    logic                rst;
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [ADDR_W-1:0]   paddr;
    logic [DATA_W-1:0]   pwdata;
    logic [DATA_W-1:0]   prdata;
    logic                pready;
    logic                pslverr;
    logic [MATRIX_N-1:0] row;
    logic [MATRIX_N-1:0] colr;
    logic [MATRIX_N-1:0] colg;
    logic                expired;

    logic [15:0] lfsr;
    int          cycle;
    int          limit;
    int          exp_load;   // model of LOAD
    int          exp_period; // model of PERIOD

    countdown_display_top #(.PERIOD_W(16)) UUT (.*);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (limit != 0 && cycle >= limit)
        begin
            $display("timeout: the countdown tests did not end within %0d cycles", limit);
            $display("Simulation FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw(input int nbits, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < nbits; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else
        begin
            $display("** Error %s: expected %0h, actual %0h", name, exp, act);
            $display("Simulation FAILED");
            $fatal(1, "stopped at the first error");
        end
    endtask

    // called 1 ns after an edge, returns 1 ns after the edge closing the access
    task automatic apb_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #4;
        rdata = prdata; // mid access cycle
        err = pslverr;
        check("pready", 1, pready);
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic bus_access(input logic wr, input logic [ADDR_W-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        logic [31:0] gap;
        draw(2, gap);
        repeat (gap)
        begin
            @(posedge clk);
            #1;
        end
        apb_xfer(wr, addr, wdata, rdata, err);
    endtask

    task automatic register_tests();
        logic [31:0]       v;
        logic [31:0]       rd;
        logic              err;
        logic [ADDR_W-1:0] bad_addr;
        for (int i = 0; i < 8; i++)
        begin
            draw(3, v);
            exp_load = v % 6;
            bus_access(1'b1, LOAD_OFS, exp_load, rd, err);
            check("load write", 0, err);
            draw(16, v);
            exp_period = v;
            bus_access(1'b1, PERIOD_OFS, exp_period, rd, err);
            check("period write", 0, err);
            draw(3, v);
            bus_access(1'b1, LOAD_OFS, v + 6, rd, err);
            check("load out of range", 1, err);
            draw(4, v);
            bad_addr = (v[1:0] == 2'b00) ? {v[3:2], 2'b10} : v[3:0];
            draw(32, v);
            bus_access(1'b1, bad_addr, v, rd, err);
            check("unmapped write", 1, err);
            bus_access(1'b0, bad_addr, 0, rd, err);
            check("unmapped read", 1, err);
            bus_access(1'b0, LOAD_OFS, 0, rd, err);
            check("load readback", exp_load, rd);
            bus_access(1'b0, PERIOD_OFS, 0, rd, err);
            check("period readback", exp_period, rd);
        end
    endtask

    task automatic run_countdown(input int load, input int per, input bit finish);
        logic [31:0] rd;
        logic        err;
        int          eff;
        int          c0;
        int          left;
        eff = (per == 0) ? 1 : per;
        bus_access(1'b1, LOAD_OFS, load, rd, err);
        bus_access(1'b1, PERIOD_OFS, per, rd, err);
        bus_access(1'b1, CTRL_OFS, 32'h1, rd, err);
        check("start accepted", 0, err);
        c0 = cycle; // start edge
        check("expired after start", load == 0, expired);
        if (finish && eff >= 2)
        begin
            for (int k = 1; k <= load; k++)
            begin
                while (cycle < c0 + k * eff - 1)
                begin
                    @(posedge clk);
                    #1;
                end
                check("expired before boundary", 0, expired);
                apb_xfer(1'b0, STATUS_OFS, 0, rd, err); // samples right after boundary k
                left = load - k;
                check("status digit", left, rd[2:0]);
                check("status running", left != 0, rd[STATUS_RUN_BIT]);
                check("status done", left == 0, rd[STATUS_DONE_BIT]);
            end
            check("expired at end", 1, expired);
        end
        else if (finish)
        begin
            while (!expired)
            begin
                @(posedge clk);
                #1;
            end
            check("countdown length", load * eff, cycle - c0);
        end
    endtask

    task automatic check_frames(input int d);
        logic [MATRIX_N-1:0] r [0:15];
        logic [MATRIX_N-1:0] cr [0:15];
        logic [MATRIX_N-1:0] cg [0:15];
        logic                red;
        logic                green;
        logic                any_r;
        logic                any_g;
        red = (d >= 2 && d <= 5);
        green = (d <= 3);
        any_r = 1'b0;
        any_g = 1'b0;
        repeat (2)
        begin
            @(posedge clk);
            #1;
        end
        for (int i = 0; i < 16; i++)
        begin
            r[i] = row;
            cr[i] = colr;
            cg[i] = colg;
            @(posedge clk);
            #1;
        end
        for (int i = 0; i < 16; i++)
        begin
            check("one row selected", 1, $onehot(~r[i]));
            if (i > 0)
                check("row order", {r[i-1][MATRIX_N-2:0], r[i-1][MATRIX_N-1]}, r[i]);
            if (i >= 8)
            begin
                check("frame repeat colr", cr[i-8], cr[i]);
                check("frame repeat colg", cg[i-8], cg[i]);
            end
            if (!red)
                check("colr off", 0, cr[i]);
            if (!green)
                check("colg off", 0, cg[i]);
            if (red && green)
                check("yellow colr equals colg", cg[i], cr[i]);
            any_r = any_r | (cr[i] != 0);
            any_g = any_g | (cg[i] != 0);
        end
        if (red)
            check("red lit", 1, any_r);
        if (green)
            check("green lit", 1, any_g);
    endtask

    initial
    begin
        logic [31:0] v;
        logic [31:0] rd;
        logic        err;
        int          run_load [NRUNS];
        int          run_per [NRUNS];
        int          restart_load;
        int          sum;
        lfsr = 16'd92;
        cycle = 0;
        limit = 0;
        sum = 0;
        rst = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        for (int i = 0; i < NRUNS; i++)
        begin
            draw(3, v);
            run_load[i] = v % 6;
            draw(4, v);
            run_per[i] = v % 10; // 0 and 1 are not polled
            sum += run_load[i] * ((run_per[i] == 0) ? 1 : run_per[i]);
        end
        draw(3, v);
        restart_load = 1 + v % 5;
        sum += 5 * 8 + restart_load * 8;
        limit = 2 * sum + 2000;

        repeat (2) @(posedge clk);
        #1;
        check("row in reset", 8'hFF, row);
        check("colr in reset", 0, colr);
        check("colg in reset", 0, colg);
        rst = 1'b0;
        bus_access(1'b0, STATUS_OFS, 0, rd, err);
        check("status after reset", 32'h7, rd); // blank, idle
        check_frames(DIGIT_BLANK);

        register_tests();
        for (int d = 0; d <= 5; d++)
        begin
            run_countdown(d, HOLD, 1'b0);
            check_frames(d);
        end
        for (int i = 0; i < NRUNS; i++)
            run_countdown(run_load[i], run_per[i], 1'b1);

        // restart while the first count is still running
        run_countdown(5, 8, 1'b0);
        repeat (7)
        begin
            @(posedge clk);
            #1;
        end
        run_countdown(restart_load, 8, 1'b1);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
source/display_pkg.sv
source/apb_map_pkg.sv
source/countdown_regs.sv
source/countdown_unit.sv
source/dot_matrix_scan.sv
source/countdown_display_top.sv
verification/countdown_display_properties.sv
verification/tb_countdown_display.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_countdown_display
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
